// ==== dbg_bus_decode.sv ====
`include "mcu_macros.svh"

module dbg_bus_decode
    import mcu_pkg::*;
(
    input  logic        sysclk,
    input  logic        rst,
    input  logic [15:0] dbg_av_address,
    input  logic        dbg_av_write,
    input  logic [15:0] dbg_av_writedata,
    input  logic        dbg_av_read,
    input  logic        tx_busy,
    output logic        dbg_av_waitrequest,
    output reg_write_t  wr,
    output reg_read_t   rd
);

    localparam logic [15:0] ADDR_LIMIT = `NUM_REG;
    localparam logic [15:0] ADDR_TX_DATA = `REG_TX_DATA;
    localparam logic [15:0] ADDR_TX_CTRL = `REG_TX_CTRL;
    localparam logic [`REG_ADDR_W-1:0] IDX_TX_CTRL = `REG_TX_CTRL;
    localparam logic [`REG_ADDR_W-1:0] IDX_LIMIT = `NUM_REG;

    logic in_range;
    logic tx_reg;
    logic start_in_wr;
    logic start_pend;
    logic tx_committed;
    logic wr_acc;
    logic rd_acc;

    // address decode on the full 16-bit address
    assign in_range = (dbg_av_address < ADDR_LIMIT);
    assign tx_reg = (dbg_av_address == ADDR_TX_DATA) || (dbg_av_address == ADDR_TX_CTRL);

    // a start already sitting on wr, pulses tx_start next cycle
    assign start_in_wr = wr.valid && (wr.idx == IDX_TX_CTRL) && wr.data[0];

    // transmitter is busy or about to be
    // covers the two cycles before tx_busy rises
    assign tx_committed = tx_busy || start_in_wr || start_pend;

    // stall only writes to the transmitter registers
    assign dbg_av_waitrequest = dbg_av_write && tx_reg && tx_committed;

    assign wr_acc = dbg_av_write && !dbg_av_waitrequest;
    assign rd_acc = dbg_av_read && !dbg_av_waitrequest;

    always_ff @(posedge sysclk) begin
        // payload fields, only meaningful with valid
        if (wr_acc) begin
            wr.idx  <= dbg_av_address[`REG_ADDR_W-1:0];
            wr.data <= dbg_av_writedata;
        end
        // out of range reads map to an index with no register
        if (rd_acc) begin
            rd.idx <= in_range ? dbg_av_address[`REG_ADDR_W-1:0] : '1;
        end

        if (rst) begin
            wr.valid   <= 1'b0;
            rd.valid   <= 1'b0;
            start_pend <= 1'b0;
        end else begin
            // out of range writes accepted but dropped here
            wr.valid   <= wr_acc && in_range;
            // every accepted read returns data
            rd.valid   <= rd_acc;
            start_pend <= start_in_wr;
        end
    end

    // no write reaches the register bank outside the register file
    a_wr_idx_range: assert property (
        @(posedge sysclk) disable iff (rst)
        wr.valid |-> (wr.idx < IDX_LIMIT)
    );

endmodule

// ==== io_top.sv ====
module io_top
    import mcu_pkg::*;
(
    input  logic        sysclk,
    input  logic        rst,
    // debug master port
    input  logic [15:0] dbg_av_address,
    input  logic        dbg_av_write,
    input  logic [15:0] dbg_av_writedata,
    input  logic        dbg_av_read,
    output logic        dbg_av_waitrequest,
    output logic [15:0] dbg_av_readdata,
    output logic        dbg_av_readdatavalid,
    // board outputs
    output logic [7:0]  led,
    output logic        serial_tx
);

    // decode to register bank
    reg_write_t wr;
    reg_read_t  rd;

    // register bank to transmitter and back
    logic       tx_start;
    logic [7:0] tx_byte;
    logic       tx_busy;

    dbg_bus_decode u_dbg_bus_decode (
        .sysclk             (sysclk),
        .rst                (rst),
        .dbg_av_address     (dbg_av_address),
        .dbg_av_write       (dbg_av_write),
        .dbg_av_writedata   (dbg_av_writedata),
        .dbg_av_read        (dbg_av_read),
        .tx_busy            (tx_busy),
        .dbg_av_waitrequest (dbg_av_waitrequest),
        .wr                 (wr),
        .rd                 (rd)
    );

    reg_bank u_reg_bank (
        .sysclk               (sysclk),
        .rst                  (rst),
        .wr                   (wr),
        .rd                   (rd),
        .tx_busy              (tx_busy),
        .led                  (led),
        .tx_byte              (tx_byte),
        .tx_start             (tx_start),
        .dbg_av_readdata      (dbg_av_readdata),
        .dbg_av_readdatavalid (dbg_av_readdatavalid)
    );

    // 8N1 transmitter on the sysclk domain
    uart_tx u_uart_tx (
        .sysclk    (sysclk),
        .rst       (rst),
        .tx_start  (tx_start),
        .tx_byte   (tx_byte),
        .serial_tx (serial_tx),
        .tx_busy   (tx_busy)
    );

endmodule

// ==== mcu_macros.svh ====
`ifndef MCU_MACROS_SVH
`define MCU_MACROS_SVH

// general-purpose registers sit at indices 0 to 7
`define NUM_GP 8

// I/O registers follow the general-purpose block
`define REG_LED 8
`define REG_TX_DATA 9
`define REG_TX_CTRL 10

// total register count, anything at or above is ignored
`define NUM_REG 11

// register index width on the internal links
`define REG_ADDR_W 4

// sysclk cycles per serial bit, small value for simulation
`define CLKS_PER_BIT 16

`endif

// ==== mcu_pkg.sv ====
`include "mcu_macros.svh"

package mcu_pkg;

    // write request from the bus decode stage
    typedef struct packed {
        logic                   valid;
        logic [`REG_ADDR_W-1:0] idx;
        logic [15:0]            data;
    } reg_write_t;

    // read request from the bus decode stage
    // idx above the register count reads as zero
    typedef struct packed {
        logic                   valid;
        logic [`REG_ADDR_W-1:0] idx;
    } reg_read_t;

    // serial transmitter states, one per frame section
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

endpackage

// ==== reg_bank.sv ====
`include "mcu_macros.svh"

module reg_bank
    import mcu_pkg::*;
(
    input  logic        sysclk,
    input  logic        rst,
    input  reg_write_t  wr,
    input  reg_read_t   rd,
    input  logic        tx_busy,
    output logic [7:0]  led,
    output logic [7:0]  tx_byte,
    output logic        tx_start,
    output logic [15:0] dbg_av_readdata,
    output logic        dbg_av_readdatavalid
);

    localparam logic [`REG_ADDR_W-1:0] IDX_TX_CTRL = `REG_TX_CTRL;
    localparam logic [`REG_ADDR_W-1:0] IDX_LIMIT = `NUM_REG;

    // general-purpose block then LED, tx data, tx control
    logic [15:0] regs [`NUM_REG];
    logic [15:0] rd_word;
    logic        wr_start;

    // bit 0 of the control register kicks the transmitter
    assign wr_start = wr.valid && (wr.idx == IDX_TX_CTRL) && wr.data[0];

    always_ff @(posedge sysclk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_REG; i++) begin
                regs[i] <= '0;
            end
            tx_start <= 1'b0;
        end else begin
            if (wr.valid) begin
                regs[wr.idx] <= wr.data;
            end
            // pulse lines up with the register update
            tx_start <= wr_start;
        end
    end

    // I/O plumbing
    assign led = regs[`REG_LED][7:0];
    assign tx_byte = regs[`REG_TX_DATA][7:0];

    // read mux
    // control read shows busy in bit 1, start bit reads back zero
    always_comb begin
        rd_word = '0;
        if (rd.idx == IDX_TX_CTRL) begin
            rd_word = {regs[`REG_TX_CTRL][15:2], tx_busy, 1'b0};
        end else if (rd.idx < IDX_LIMIT) begin
            rd_word = regs[rd.idx];
        end
    end

    // read data two cycles after the bus accepted it
    always_ff @(posedge sysclk) begin
        if (rd.valid) begin
            dbg_av_readdata <= rd_word;
        end

        if (rst) begin
            dbg_av_readdatavalid <= 1'b0;
        end else begin
            dbg_av_readdatavalid <= rd.valid;
        end
    end

    // decode stalls must keep a second start away from a running frame
    a_no_start_when_busy: assert property (
        @(posedge sysclk) disable iff (rst)
        $rose(tx_start) |-> !tx_busy
    );

endmodule

// ==== tb_io_top.sv ====
`include "mcu_macros.svh"

module tb_io_top;
    timeunit 1ns;
    timeprecision 100ps;

    // table operations
    // exp holds the stall flag for writes
    typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_LED, OP_FRAME, OP_WAIT, OP_SYNC} op_t;

    typedef struct packed {
        op_t         op;
        logic [15:0] addr;
        logic [15:0] data;
        logic [15:0] exp;
    } entry_t;

    logic        sysclk = 1'b0;
    logic        rst;
    logic [15:0] dbg_av_address;
    logic        dbg_av_write;
    logic [15:0] dbg_av_writedata;
    logic        dbg_av_read;
    logic        dbg_av_waitrequest;
    logic [15:0] dbg_av_readdata;
    logic        dbg_av_readdatavalid;
    logic [7:0]  led;
    logic        serial_tx;

    entry_t      stim_q[$];
    logic [31:0] rng;
    logic [15:0] gp_val [`NUM_GP];
    logic [7:0]  frame_byte;
    logic        frame_active;

    io_top u_io_top (
        .sysclk               (sysclk),
        .rst                  (rst),
        .dbg_av_address       (dbg_av_address),
        .dbg_av_write         (dbg_av_write),
        .dbg_av_writedata     (dbg_av_writedata),
        .dbg_av_read          (dbg_av_read),
        .dbg_av_waitrequest   (dbg_av_waitrequest),
        .dbg_av_readdata      (dbg_av_readdata),
        .dbg_av_readdatavalid (dbg_av_readdatavalid),
        .led                  (led),
        .serial_tx            (serial_tx)
    );

    // 4 ns period
    always #2 sysclk = ~sysclk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    task automatic raise_error(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // drive point half a ns after the rising edge
    task automatic step_cycle();
        @(posedge sysclk);
        #0.5;
    endtask

    task automatic push_entry(input op_t op, input logic [15:0] addr,
                              input logic [15:0] data, input logic [15:0] exp);
        stim_q.push_back(entry_t'{op, addr, data, exp});
    endtask

    task automatic write_word(input logic [15:0] addr, input logic [15:0] data,
                              input logic stall_exp);
        int n;
        n = 0;
        dbg_av_address   = addr;
        dbg_av_writedata = data;
        dbg_av_write     = 1'b1;
        #1;
        // hold strobe, address and data while stalled
        while (dbg_av_waitrequest) begin
            assert (n < 400) else raise_error("write stayed stalled by waitrequest too long");
            @(posedge sysclk);
            #1.5;
            n++;
        end
        assert ((n > 0) == stall_exp) else raise_error($sformatf(
            "Error dbg_av_waitrequest expected %0h got %0h", stall_exp, n > 0));
        step_cycle();
        dbg_av_write = 1'b0;
    endtask

    task automatic read_word(input logic [15:0] addr, input logic [15:0] exp);
        int n;
        n = 0;
        dbg_av_address = addr;
        dbg_av_read    = 1'b1;
        #1;
        while (dbg_av_waitrequest) begin
            assert (n < 400) else raise_error("read stayed stalled by waitrequest too long");
            @(posedge sysclk);
            #1.5;
            n++;
        end
        step_cycle();
        dbg_av_read = 1'b0;
        // count cycles from acceptance with data due in the second
        n = 1;
        #1;
        while (!dbg_av_readdatavalid) begin
            assert (n < 6) else raise_error("no readdatavalid after an accepted read");
            @(posedge sysclk);
            #1.5;
            n++;
        end
        assert (n == 2) else raise_error($sformatf(
            "Error dbg_av_readdatavalid expected latency %0h got %0h", 2, n));
        assert (dbg_av_readdata === exp) else raise_error($sformatf(
            "Error dbg_av_readdata expected %04h got %04h at address %04h",
            exp, dbg_av_readdata, addr));
        step_cycle();
    endtask

    // serial frame sampler running beside the bus traffic
    task automatic sample_frame(input logic [7:0] b);
        int         n;
        logic [9:0] bits;
        n = 0;
        #1;
        while (serial_tx) begin
            assert (n < 12) else raise_error("no start bit appeared on serial_tx");
            @(posedge sysclk);
            #1.5;
            n++;
        end
        // move to mid-bit
        repeat (`CLKS_PER_BIT / 2) @(posedge sysclk);
        #1.5;
        for (int i = 0; i < 10; i++) begin
            bits[i] = serial_tx;
            if (i < 9) begin
                repeat (`CLKS_PER_BIT) @(posedge sysclk);
                #1.5;
            end
        end
        assert (bits[0] === 1'b0) else raise_error("start bit on serial_tx is not low");
        // LSB first
        assert (bits[8:1] === b) else raise_error($sformatf(
            "Error serial_tx expected data %02h got %02h", b, bits[8:1]));
        assert (bits[9] === 1'b1) else raise_error("stop bit on serial_tx is not high");
        frame_active = 1'b0;
    endtask

    initial begin
        int n;
        rst              = 1'b1;
        dbg_av_address   = '0;
        dbg_av_write     = 1'b0;
        dbg_av_writedata = '0;
        dbg_av_read      = 1'b0;
        rng              = 32'hf7b53d8c;
        frame_byte       = '0;
        frame_active     = 1'b0;

        // reset state and every register reads zero
        for (int i = 0; i < `NUM_REG; i++) begin
            push_entry(OP_READ, i, 16'h0000, 16'h0000);
        end
        // random data with each read right behind its write
        for (int i = 0; i < `NUM_GP; i++) begin
            rng = xorshift32(rng);
            gp_val[i] = rng[15:0];
            push_entry(OP_WRITE, i, gp_val[i], 16'h0000);
            push_entry(OP_READ, i, 16'h0000, gp_val[i]);
        end
        push_entry(OP_WRITE, `REG_LED, 16'h5ac3, 16'h0000);
        push_entry(OP_LED, 16'h0000, 16'h0000, 16'h00c3);
        push_entry(OP_READ, `REG_LED, 16'h0000, 16'h5ac3);
        // out of range address whose low bits alias register 3
        push_entry(OP_WRITE, 16'h0013, 16'hffff, 16'h0000);
        push_entry(OP_READ, 16'h0013, 16'h0000, 16'h0000);
        push_entry(OP_READ, 16'h8003, 16'h0000, 16'h0000);
        push_entry(OP_READ, 16'h0003, 16'h0000, gp_val[3]);
        // first frame, busy read, stalled data write
        push_entry(OP_WRITE, `REG_TX_DATA, 16'h00a5, 16'h0000);
        push_entry(OP_WRITE, `REG_TX_CTRL, 16'h0001, 16'h0000);
        push_entry(OP_FRAME, 16'h0000, 16'h00a5, 16'h0000);
        push_entry(OP_WAIT, 16'h0000, 16'd4, 16'h0000);
        push_entry(OP_READ, `REG_TX_CTRL, 16'h0000, 16'h0002);
        push_entry(OP_WRITE, `REG_TX_DATA, 16'h003c, 16'h0001);
        push_entry(OP_SYNC, 16'h0000, 16'h0000, 16'h0000);
        push_entry(OP_READ, `REG_TX_DATA, 16'h0000, 16'h003c);
        // second frame carries the stalled byte
        push_entry(OP_WRITE, `REG_TX_CTRL, 16'h0001, 16'h0000);
        push_entry(OP_FRAME, 16'h0000, 16'h003c, 16'h0000);
        push_entry(OP_SYNC, 16'h0000, 16'h0000, 16'h0000);
        push_entry(OP_WAIT, 16'h0000, 16'd12, 16'h0000);
        push_entry(OP_READ, `REG_TX_CTRL, 16'h0000, 16'h0000);

        repeat (16) @(posedge sysclk);
        #0.5;
        rst = 1'b0;
        #1;
        assert (led === 8'h00) else raise_error($sformatf(
            "Error led expected %02h got %02h", 8'h00, led));
        assert (serial_tx === 1'b1) else raise_error($sformatf(
            "Error serial_tx expected %0h got %0h", 1'b1, serial_tx));
        assert (dbg_av_waitrequest === 1'b0) else raise_error($sformatf(
            "Error dbg_av_waitrequest expected %0h got %0h", 1'b0, dbg_av_waitrequest));
        step_cycle();

        foreach (stim_q[k]) begin
            case (stim_q[k].op)
                OP_WRITE: write_word(stim_q[k].addr, stim_q[k].data, stim_q[k].exp[0]);
                OP_READ:  read_word(stim_q[k].addr, stim_q[k].exp);
                OP_LED: begin
                    // old value one cycle after acceptance and new value a cycle later
                    #1;
                    assert (led === stim_q[k].data[7:0]) else raise_error($sformatf(
                        "Error led expected %02h got %02h", stim_q[k].data[7:0], led));
                    @(posedge sysclk);
                    #1.5;
                    assert (led === stim_q[k].exp[7:0]) else raise_error($sformatf(
                        "Error led expected %02h got %02h", stim_q[k].exp[7:0], led));
                    step_cycle();
                end
                OP_FRAME: begin
                    frame_byte   = stim_q[k].data[7:0];
                    frame_active = 1'b1;
                    fork
                        sample_frame(frame_byte);
                    join_none
                end
                OP_WAIT: repeat (stim_q[k].data) step_cycle();
                OP_SYNC: begin
                    n = 0;
                    while (frame_active) begin
                        assert (n < 400) else raise_error("serial frame did not finish in time");
                        step_cycle();
                        n++;
                    end
                end
                default: raise_error("unknown operation in the stimulus table");
            endcase
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// ==== uart_tx.sv ====
`include "mcu_macros.svh"

module uart_tx
    import mcu_pkg::*;
(
    input  logic       sysclk,
    input  logic       rst,
    input  logic       tx_start,
    input  logic [7:0] tx_byte,
    output logic       serial_tx,
    output logic       tx_busy
);

    // wide enough for any bit period
    localparam int CNT_W = $clog2(`CLKS_PER_BIT + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`CLKS_PER_BIT - 1);

    tx_state_t        state;
    logic [CNT_W-1:0] bit_cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shreg;
    logic             bit_end;

    // last sysclk of the current serial bit
    assign bit_end = (bit_cnt == CNT_LAST);

    // busy covers start, data and stop bits
    assign tx_busy = (state != TX_IDLE);

    // byte latched at start, shifted out LSB first
    always_ff @(posedge sysclk) begin
        if (state == TX_IDLE && tx_start) begin
            shreg <= tx_byte;
        end else if (state == TX_DATA && bit_end) begin
            shreg <= shreg >> 1;
        end
    end

    always_ff @(posedge sysclk) begin
        if (rst) begin
            state     <= TX_IDLE;
            bit_cnt   <= '0;
            bit_idx   <= '0;
            serial_tx <= 1'b1;
        end else begin
            // bit period counter, parked at zero while idle
            if (state == TX_IDLE || bit_end) begin
                bit_cnt <= '0;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end

            case (state)
                TX_IDLE: begin
                    // line idles high
                    serial_tx <= 1'b1;
                    if (tx_start) begin
                        state     <= TX_START;
                        serial_tx <= 1'b0;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        state     <= TX_DATA;
                        bit_idx   <= '0;
                        serial_tx <= shreg[0];
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        if (bit_idx == 3'd7) begin
                            // one stop bit
                            state     <= TX_STOP;
                            serial_tx <= 1'b1;
                        end else begin
                            bit_idx   <= bit_idx + 1'b1;
                            // next bit before the shift lands
                            serial_tx <= shreg[1];
                        end
                    end
                end
                TX_STOP: begin
                    if (bit_end) begin
                        state <= TX_IDLE;
                    end
                end
                default: begin
                    state     <= TX_IDLE;
                    serial_tx <= 1'b1;
                end
            endcase
        end
    end

    // idle line must never sit low between frames
    a_idle_high: assert property (
        @(posedge sysclk) disable iff (rst)
        (state == TX_IDLE) |-> serial_tx
    );

endmodule

// ==== vlog.f ====
+incdir+.
mcu_pkg.sv
dbg_bus_decode.sv
reg_bank.sv
uart_tx.sv
io_top.sv
tb_io_top.sv
